/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	localparam int XLEN = 32;
	localparam int REG_AW = 5;
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;

	localparam logic [2:0] F3_JALR = 3'b000;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_LW = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;
	localparam logic [2:0] F3_ADD = 3'b000; // addi and add
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLTU = 3'b011; // sltiu and sltu
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SRA = 7'b0100000;

	typedef logic [XLEN-1:0] word_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm11_0;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm31_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		word_t raw;
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_t;

endpackage

`default_nettype wire

/* hdl/rv_decode.sv */
`default_nettype none

module rv_decode import rv_pkg::*; (
	input instr_t instr,
	output logic [6:0] opcode,
	output logic [2:0] funct3,
	output logic [6:0] funct7,
	output logic [REG_AW-1:0] rs1,
	output logic [REG_AW-1:0] rs2,
	output logic [REG_AW-1:0] rd,
	output word_t imm,
	output logic known
);

	assign opcode = instr.r.opcode;
	assign funct3 = instr.r.funct3;
	assign funct7 = instr.r.funct7;
	assign rs1 = instr.r.rs1;
	assign rs2 = instr.r.rs2;
	assign rd = instr.r.rd;

	always_comb begin
		case (instr.r.opcode)
			OP_LUI, OP_AUIPC: imm = {instr.u.imm31_12, 12'b0};
			OP_JAL: imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
				instr.j.imm11, instr.j.imm10_1, 1'b0};
			OP_BRANCH: imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
				instr.b.imm10_5, instr.b.imm4_1, 1'b0};
			OP_STORE: imm = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
			default: imm = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0}; // I format
		endcase
	end

	always_comb begin
		known = 1'b0;
		case (instr.r.opcode)
			OP_LUI, OP_AUIPC, OP_JAL: known = 1'b1;
			OP_JALR: known = (funct3 == F3_JALR);
			OP_BRANCH: known = (funct3 == F3_BEQ) || (funct3 == F3_BNE) || (funct3 == F3_BGE);
			OP_LOAD: known = (funct3 == F3_LW) || (funct3 == F3_LBU);
			OP_STORE: known = (funct3 == F3_SB) || (funct3 == F3_SH) || (funct3 == F3_SW);
			OP_IMM: begin
				case (funct3)
					F3_ADD, F3_SLTU, F3_XOR, F3_AND: known = 1'b1;
					F3_SLL: known = (funct7 == F7_BASE); // shamt lives in rs2 slot
					F3_SR: known = (funct7 == F7_SRA); // srai only, no srli
					default: known = 1'b0;
				endcase
			end
			OP_REG: begin
				case (funct3)
					F3_ADD, F3_SLL, F3_SLTU, F3_AND: known = (funct7 == F7_BASE);
					default: known = 1'b0;
				endcase
			end
			default: known = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/rv_regfile.sv */
`default_nettype none

module rv_regfile import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic we,
	input logic [REG_AW-1:0] waddr,
	input word_t wdata,
	input logic [REG_AW-1:0] raddr1,
	input logic [REG_AW-1:0] raddr2,
	output word_t rdata1,
	output word_t rdata2
);

	word_t regs [2**REG_AW]; // entry 0 never written

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	always_ff @(posedge clk) begin
		if (!rst && we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// core must keep step low through reset
	assert property (@(posedge clk) rst |-> !we);

endmodule

`default_nettype wire

/* hdl/rv_exu.sv */
`default_nettype none

module rv_exu import rv_pkg::*; (
	input logic [6:0] opcode,
	input logic [2:0] funct3,
	input logic [6:0] funct7,
	input word_t src1,
	input word_t src2,
	input word_t imm,
	input word_t pc,
	input word_t load_data,
	output word_t val,
	output word_t jump,
	output word_t mem_addr,
	output logic [3:0] wmask,
	output logic wen
);

	word_t diff;
	word_t target;
	word_t link;
	logic br_eq;
	logic br_ge;

	assign diff = src1 - src2;
	assign br_eq = (diff == '0);
	assign br_ge = $signed(src1) >= $signed(src2); // bge is signed
	assign target = pc + imm;
	assign link = pc + 32'd4;
	assign mem_addr = src1 + imm;
	assign wen = (opcode == OP_STORE);

	always_comb begin
		val = '0;
		case (opcode)
			OP_LUI: val = imm;
			OP_AUIPC: val = target;
			OP_JAL, OP_JALR: val = link;
			OP_LOAD: begin
				case (funct3)
					F3_LW: val = load_data;
					F3_LBU: val = {24'b0, load_data[7:0]}; // zero extend
					default: val = '0;
				endcase
			end
			OP_IMM: begin
				case (funct3)
					F3_ADD: val = src1 + imm;
					F3_SLTU: val = {31'b0, src1 < imm}; // unsigned compare
					F3_XOR: val = src1 ^ imm;
					F3_AND: val = src1 & imm;
					F3_SLL: val = src1 << imm[4:0];
					F3_SR: begin
						if (funct7 == F7_SRA) begin
							val = word_t'($signed(src1) >>> imm[4:0]);
						end
					end
					default: val = '0;
				endcase
			end
			OP_REG: begin
				if (funct7 == F7_BASE) begin
					case (funct3)
						F3_ADD: val = src1 + src2;
						F3_SLL: val = src1 << src2[4:0];
						F3_SLTU: val = {31'b0, src1 < src2};
						F3_AND: val = src1 & src2;
						default: val = '0;
					endcase
				end
			end
			default: val = '0;
		endcase
	end

	// zero means fall through to pc + 4
	always_comb begin
		jump = '0;
		case (opcode)
			OP_JAL: jump = target;
			OP_JALR: jump = mem_addr & ~32'd1;
			OP_BRANCH: begin
				case (funct3)
					F3_BEQ: jump = br_eq ? target : '0;
					F3_BNE: jump = br_eq ? '0 : target;
					F3_BGE: jump = br_ge ? target : '0;
					default: jump = '0;
				endcase
			end
			default: jump = '0;
		endcase
	end

	always_comb begin
		case ({funct3, opcode})
			{F3_SB, OP_STORE}: wmask = 4'h1;
			{F3_SH, OP_STORE}: wmask = 4'h3;
			{F3_SW, OP_STORE}: wmask = 4'hf;
			default: wmask = 4'h0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/rv_dmem.sv */
`default_nettype none

module rv_dmem import rv_pkg::*; (
	input logic clk,
	input word_t addr,
	input word_t wdata,
	input logic [3:0] wmask,
	input logic we,
	output word_t rdata
);

	word_t mem [DMEM_WORDS];
	logic [DMEM_AW-1:0] idx;

	assign idx = addr[2 +: DMEM_AW]; // low two bits dropped
	assign rdata = mem[idx];

	always_ff @(posedge clk) begin
		if (we) begin
			for (int b = 0; b < 4; b++) begin
				if (wmask[b]) begin
					mem[idx][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`default_nettype none

module rv_core import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic step,
	input instr_t instr,
	output word_t pc,
	output word_t ret_next_pc,
	output word_t ret_data,
	output logic ret_valid,
	output logic ret_we,
	output logic illegal,
	output logic [REG_AW-1:0] ret_rd
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [REG_AW-1:0] rs1;
	logic [REG_AW-1:0] rs2;
	logic [REG_AW-1:0] rd;
	word_t imm;
	word_t src1;
	word_t src2;
	word_t val;
	word_t jump;
	word_t mem_addr;
	word_t rdata;
	word_t next_pc;
	logic [3:0] wmask;
	logic known;
	logic wen;
	logic writes_rd;
	logic reg_we;

	rv_decode u_decode (
		.instr (instr),
		.opcode (opcode),
		.funct3 (funct3),
		.funct7 (funct7),
		.rs1 (rs1),
		.rs2 (rs2),
		.rd (rd),
		.imm (imm),
		.known (known)
	);

	rv_regfile u_regfile (
		.clk (clk),
		.rst (rst),
		.we (reg_we),
		.waddr (rd),
		.wdata (val),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.rdata1 (src1),
		.rdata2 (src2)
	);

	rv_exu u_exu (
		.opcode (opcode),
		.funct3 (funct3),
		.funct7 (funct7),
		.src1 (src1),
		.src2 (src2),
		.imm (imm),
		.pc (pc),
		.load_data (rdata), // lw or lbu picked inside
		.val (val),
		.jump (jump),
		.mem_addr (mem_addr),
		.wmask (wmask),
		.wen (wen)
	);

	rv_dmem u_dmem (
		.clk (clk),
		.addr (mem_addr),
		.wdata (src2),
		.wmask (wmask),
		.we (step && known && wen),
		.rdata (rdata)
	);

	assign writes_rd = (opcode != OP_BRANCH) && (opcode != OP_STORE);
	assign reg_we = step && known && writes_rd && (rd != '0);
	assign next_pc = (known && jump != '0) ? jump : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (step) begin
			pc <= next_pc;
		end
	end

	assign ret_valid = step;
	assign ret_we = reg_we;
	assign ret_rd = rd;
	assign ret_data = val;
	assign ret_next_pc = next_pc;
	assign illegal = step && !known;

	// jalr clears bit 0 only, so bit 1 relies on the program
	assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* tests/tb_rv_core.sv */
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

	localparam int NUM_ROWS = 33;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 2 + 20;

	logic clk;
	logic rst;
	logic step;
	instr_t instr;
	word_t pc;
	word_t ret_next_pc;
	word_t ret_data;
	logic ret_valid;
	logic ret_we;
	logic illegal;
	logic [REG_AW-1:0] ret_rd;

	// one row per step cycle
	logic t_step [NUM_ROWS];
	word_t t_instr [NUM_ROWS];
	logic t_we [NUM_ROWS];
	logic [REG_AW-1:0] t_rd [NUM_ROWS];
	word_t t_data [NUM_ROWS];
	word_t t_pc [NUM_ROWS];
	word_t t_next [NUM_ROWS];
	logic t_ill [NUM_ROWS];

	int n_rows = 0;
	word_t exp_pc = '0;
	int seed = 32'had6b;
	int cycles = 0;
	word_t rnd;
	word_t hi;

	rv_core u_rv_core (
		.clk (clk),
		.rst (rst),
		.step (step),
		.instr (instr),
		.pc (pc),
		.ret_next_pc (ret_next_pc),
		.ret_data (ret_data),
		.ret_valid (ret_valid),
		.ret_we (ret_we),
		.illegal (illegal),
		.ret_rd (ret_rd)
	);

	function automatic word_t r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
	endfunction

	function automatic word_t i_type(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic word_t s_type(int imm, int rs2, int rs1, logic [2:0] f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t b_type(int imm, int rs2, int rs1, logic [2:0] f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic word_t u_type(int imm20, int rd, logic [6:0] op);
		return {imm20[19:0], rd[4:0], op};
	endfunction

	function automatic word_t j_type(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
	endfunction

	task automatic add_row(logic stp, word_t ins, logic we, int rd, word_t data, word_t next,
		logic ill);
		t_step[n_rows] = stp;
		t_instr[n_rows] = ins;
		t_we[n_rows] = we;
		t_rd[n_rows] = rd[REG_AW-1:0];
		t_data[n_rows] = data;
		t_pc[n_rows] = exp_pc;
		t_next[n_rows] = next;
		t_ill[n_rows] = ill;
		exp_pc = next;
		n_rows++;
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_reg(string name, logic [REG_AW-1:0] got, logic [REG_AW-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin
		rst = 1'b1;
		step = 1'b0;
		instr = '0;
		rnd = $random(seed);
		hi = (rnd + 32'h800) & 32'hfffff000; // lui part, rounded for signed low half

		add_row(1, u_type(32'h80000, 1, OP_LUI), 1, 1, 32'h80000000, 4, 0);
		add_row(1, u_type(1, 2, OP_AUIPC), 1, 2, 32'h00001004, 8, 0);
		add_row(1, i_type(-1, 0, F3_ADD, 3, OP_IMM), 1, 3, 32'hffffffff, 12, 0);
		add_row(1, i_type(32'h0f0, 3, F3_XOR, 4, OP_IMM), 1, 4, 32'hffffff0f, 16, 0);
		add_row(1, i_type(32'h7ff, 4, F3_AND, 6, OP_IMM), 1, 6, 32'h0000070f, 20, 0);
		add_row(1, i_type(-1, 6, F3_SLTU, 7, OP_IMM), 1, 7, 32'h1, 24, 0);
		add_row(1, i_type(5, 3, F3_ADD, 0, OP_IMM), 0, 0, 0, 28, 0); // x0 dropped
		add_row(1, r_type(F7_BASE, 3, 1, F3_ADD, 8), 1, 8, 32'h7fffffff, 32, 0);
		add_row(1, r_type(F7_BASE, 7, 3, F3_SLL, 9), 1, 9, 32'hfffffffe, 36, 0);
		add_row(1, r_type(F7_BASE, 1, 6, F3_SLTU, 10), 1, 10, 32'h1, 40, 0);
		add_row(1, r_type(F7_BASE, 3, 1, F3_AND, 11), 1, 11, 32'h80000000, 44, 0);
		add_row(1, i_type(4, 4, F3_SLL, 12, OP_IMM), 1, 12, 32'hfffff0f0, 48, 0);
		add_row(1, i_type(32'h404, 1, F3_SR, 13, OP_IMM), 1, 13, 32'hf8000000, 52, 0);
		add_row(1, i_type(32'h40, 0, F3_ADD, 14, OP_IMM), 1, 14, 32'h40, 56, 0);
		add_row(1, u_type(int'(hi[31:12]), 5, OP_LUI), 1, 5, hi, 60, 0);
		add_row(1, i_type(int'(rnd), 5, F3_ADD, 5, OP_IMM), 1, 5, rnd, 64, 0);
		add_row(1, s_type(0, 5, 14, F3_SW), 0, 0, 0, 68, 0);
		add_row(1, i_type(0, 14, F3_LW, 15, OP_LOAD), 1, 15, rnd, 72, 0);
		add_row(1, s_type(8, 5, 14, F3_SB), 0, 0, 0, 76, 0);
		add_row(1, i_type(8, 14, F3_LBU, 16, OP_LOAD), 1, 16, {24'b0, rnd[7:0]}, 80, 0);
		add_row(1, s_type(0, 3, 14, F3_SH), 0, 0, 0, 84, 0);
		add_row(1, i_type(0, 14, F3_LW, 17, OP_LOAD), 1, 17, {rnd[31:16], 16'hffff}, 88, 0);
		add_row(1, b_type(8, 3, 3, F3_BEQ), 0, 0, 0, 96, 0);
		add_row(1, b_type(8, 3, 3, F3_BNE), 0, 0, 0, 100, 0);
		add_row(1, b_type(8, 3, 1, F3_BGE), 0, 0, 0, 104, 0); // signed, not taken
		add_row(1, b_type(12, 1, 3, F3_BGE), 0, 0, 0, 116, 0);
		add_row(1, b_type(-8, 3, 1, F3_BNE), 0, 0, 0, 108, 0);
		add_row(1, b_type(8, 3, 1, F3_BEQ), 0, 0, 0, 112, 0);
		add_row(1, j_type(12, 18), 1, 18, 32'd116, 124, 0);
		add_row(1, i_type(32'h41, 14, F3_JALR, 19, OP_JALR), 1, 19, 32'd128, 128, 0);
		add_row(1, r_type(F7_SRA, 2, 1, F3_ADD, 20), 0, 0, 0, 132, 1); // sub
		add_row(0, i_type(0, 0, F3_ADD, 3, OP_IMM), 0, 0, 0, 132, 0); // would clear x3
		add_row(1, i_type(1, 3, F3_ADD, 21, OP_IMM), 1, 21, 32'h0, 136, 0);

		if (n_rows != NUM_ROWS) begin
			$display("instruction table holds %0d rows instead of %0d", n_rows, NUM_ROWS);
			$display("Simulation FAILED");
			$fatal(1, "bad table length");
		end

		repeat (4) @(posedge clk);
		#5;
		rst = 1'b0;

		for (int i = 0; i < NUM_ROWS; i++) begin
			check_word("pc", pc, t_pc[i]);
			instr = t_instr[i];
			step = t_step[i];
			@(negedge clk);
			check_bit("ret_valid", ret_valid, t_step[i]);
			check_bit("ret_we", ret_we, t_we[i]);
			check_bit("illegal", illegal, t_ill[i]);
			if (t_we[i]) begin
				check_reg("ret_rd", ret_rd, t_rd[i]);
				check_word("ret_data", ret_data, t_data[i]);
			end
			if (t_step[i]) begin
				check_word("ret_next_pc", ret_next_pc, t_next[i]);
			end
			@(posedge clk);
			#5;
		end
		step = 1'b0;
		check_word("pc", pc, exp_pc);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_exu.sv
hdl/rv_dmem.sv
hdl/rv_core.sv
tests/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_rv_core -o sim_tb_rv_core

./obj_dir/sim_tb_rv_core
